// ==== sources.f ====
hdl/cache_cfg_pkg.sv
hdl/wb_types_pkg.sv
hdl/bank_wb_queue.sv
hdl/wb_sel_merge.sv
hdl/core_wb_stage.sv
hdl/cache_wb_top.sv
tb/cache_wb_properties.sv
tb/cache_wb_tb.sv

// ==== Bender.yml ====
package:
  name: cache_wb

sources:
  - hdl/cache_cfg_pkg.sv
  - hdl/wb_types_pkg.sv
  - hdl/bank_wb_queue.sv
  - hdl/wb_sel_merge.sv
  - hdl/core_wb_stage.sv
  - hdl/cache_wb_top.sv
  - target: test
    files:
      - tb/cache_wb_properties.sv
      - tb/cache_wb_tb.sv

// ==== tb/cache_wb_tb.sv ====
`timescale 1ns/1ps

module cache_wb_tb;

	localparam int CLK_PERIOD    = 100;
	localparam int DRAIN_LIMIT   = 20;
	// Rough cycle cost of reset and the five tests
	localparam int TEST_CYCLES   = 6 + 10 + 10 + 10 + 20 + 30;
	localparam int MARGIN_CYCLES = 50;

	logic                                                  clk;
	logic                                                  rst_n;
	logic [cache_cfg_pkg::NUM_BANKS-1:0]                   bank_push;
	wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0] bank_data;
	logic [cache_cfg_pkg::NUM_BANKS-1:0]                   bank_full;
	logic                                                  core_no_wb_slot;
	logic                                                  core_wb_valid;
	wb_types_pkg::core_wb_t                                core_wb;

	integer seed = 44417;
	int     check_errors = 0;
	int     timeouts = 0;

	// Writebacks the core should receive, oldest first
	wb_types_pkg::core_wb_t exp_q[$];

	cache_wb_top dut0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.bank_push       (bank_push),
		.bank_data       (bank_data),
		.bank_full       (bank_full),
		.core_no_wb_slot (core_no_wb_slot),
		.core_wb_valid   (core_wb_valid),
		.core_wb         (core_wb)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic wb_types_pkg::bank_wb_t rand_resp();
		wb_types_pkg::bank_wb_t r;
		r.tid      = cache_cfg_pkg::TID_BITS'($random(seed));
		r.rd       = cache_cfg_pkg::RD_BITS'($random(seed));
		r.wb       = wb_types_pkg::wb_kind_t'(2'($random(seed)));
		r.warp_num = cache_cfg_pkg::WARP_BITS'($random(seed));
		r.data     = cache_cfg_pkg::WORD_BITS'($random(seed));
		return r;
	endfunction

	// Core writeback that one response alone turns into
	function automatic wb_types_pkg::core_wb_t single_wb(input wb_types_pkg::bank_wb_t r);
		wb_types_pkg::core_wb_t w;
		w = '0;
		w.lane_valid[r.tid] = 1'b1;
		w.lane_data[r.tid]  = r.data;
		w.rd                = r.rd;
		w.wb                = r.wb;
		w.warp_num          = r.warp_num;
		return w;
	endfunction

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	// One cycle of push strobes, returns on the edge that writes the queues
	task automatic push_banks(input logic [cache_cfg_pkg::NUM_BANKS-1:0] mask,
			input wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0] d);
		@(posedge clk);
		bank_push <= mask;
		bank_data <= d;
		@(posedge clk);
		bank_push <= '0;
	endtask

	task automatic check_wb(input wb_types_pkg::core_wb_t exp, input string what);
		assert (core_wb_valid) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: %s: core_wb_valid is low", $time, what);
		end
		assert (core_wb.lane_valid == exp.lane_valid) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: %s: lane_valid %b, expected %b",
				$time, what, core_wb.lane_valid, exp.lane_valid);
		end
		for (int l = 0; l < cache_cfg_pkg::NUM_REQS; l++) begin
			if (exp.lane_valid[l]) begin
				assert (core_wb.lane_data[l] == exp.lane_data[l]) else begin
					check_errors++;
					$display("CHECK FAILED at %0t ns: %s: lane %0d data %h, expected %h",
						$time, what, l, core_wb.lane_data[l], exp.lane_data[l]);
				end
			end
		end
		assert (core_wb.rd == exp.rd && core_wb.wb == exp.wb
				&& core_wb.warp_num == exp.warp_num) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: %s: rd/wb/warp %0d/%0d/%0d, expected %0d/%0d/%0d",
				$time, what, core_wb.rd, core_wb.wb, core_wb.warp_num,
				exp.rd, exp.wb, exp.warp_num);
		end
	endtask

	// Consumes exp_q as the core takes writebacks, then expects an idle output
	task automatic drain_expected(input bit back_to_back, input string what,
			output int first_wait);
		int                     waited;
		bit                     started;
		wb_types_pkg::core_wb_t exp;
		waited     = 0;
		started    = 1'b0;
		first_wait = 0;
		while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
			if (core_wb_valid && !core_no_wb_slot) begin
				if (!started) begin
					first_wait = waited;
				end
				started = 1'b1;
				exp = exp_q.pop_front();
				check_wb(exp, what);
			end else begin
				assert (!started || !back_to_back) else begin
					check_errors++;
					$display("CHECK FAILED at %0t ns: %s: gap between writebacks", $time, what);
				end
			end
		end
		if (exp_q.size() > 0) begin
			timeouts++;
			$display("Timed out in %s: %0d expected writebacks never arrived",
				what, exp_q.size());
			exp_q.delete();
		end else begin
			@(negedge clk);
			assert (!core_wb_valid) else begin
				check_errors++;
				$display("CHECK FAILED at %0t ns: %s: extra writeback after the last one",
					$time, what);
			end
		end
	endtask

	task automatic wait_for_valid(input string what);
		int waited;
		waited = 0;
		while (!core_wb_valid && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!core_wb_valid) begin
			timeouts++;
			$display("Timed out in %s: no writeback reached the output", what);
		end
	endtask

	task automatic test_single_response();
		wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0] d;
		logic [cache_cfg_pkg::NUM_BANKS-1:0]                   mask;
		wb_types_pkg::bank_wb_t                                r;
		int                                                    bank;
		int                                                    first_wait;
		@(negedge clk);
		assert (!core_wb_valid) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: single: core_wb_valid high after reset", $time);
		end
		bank = $unsigned($random(seed)) % cache_cfg_pkg::NUM_BANKS;
		r = rand_resp();
		d = '0;
		d[bank] = r;
		mask = '0;
		mask[bank] = 1'b1;
		push_banks(mask, d);
		exp_q.push_back(single_wb(r));
		drain_expected(1'b0, "single", first_wait);
		// Push edge N, valid after edge N+1, so seen at the second falling edge
		assert (first_wait == 2) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: single: latency %0d, expected 2", $time, first_wait);
		end
	endtask

	task automatic test_merge();
		wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0] d;
		wb_types_pkg::core_wb_t                                w;
		int                                                    first_wait;
		d = '0;
		d[1] = rand_resp();
		d[3] = rand_resp();
		d[1].tid = '0;
		d[3].tid = 1;
		d[3].rd = d[1].rd;
		d[3].warp_num = d[1].warp_num;
		push_banks(4'b1010, d);
		w = single_wb(d[1]);
		w.lane_valid[d[3].tid] = 1'b1;
		w.lane_data[d[3].tid]  = d[3].data;
		exp_q.push_back(w);
		drain_expected(1'b0, "merge", first_wait);
		assert (first_wait == 2) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: merge: latency %0d, expected 2", $time, first_wait);
		end
	endtask

	task automatic test_priority();
		wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0] d;
		int                                                    first_wait;
		d = '0;
		d[0] = rand_resp();
		d[2] = rand_resp();
		d[2].rd = d[0].rd ^ 1'b1;
		push_banks(4'b0101, d);
		exp_q.push_back(single_wb(d[0]));
		exp_q.push_back(single_wb(d[2]));
		drain_expected(1'b1, "priority", first_wait);
		assert (first_wait == 2) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: priority: latency %0d, expected 2",
				$time, first_wait);
		end
	endtask

	task automatic test_back_pressure();
		wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0] d;
		int                                                    first_wait;
		@(posedge clk);
		core_no_wb_slot <= 1'b1;
		d = '0;
		for (int b = 0; b < 3; b++) begin
			d[b] = rand_resp();
			d[b].rd = cache_cfg_pkg::RD_BITS'(b + 1);
		end
		push_banks(4'b0111, d);
		wait_for_valid("back-pressure");
		check_wb(single_wb(d[0]), "back-pressure hold");
		repeat (4) begin
			@(negedge clk);
			check_wb(single_wb(d[0]), "back-pressure stall");
		end
		@(posedge clk);
		core_no_wb_slot <= 1'b0;
		for (int b = 0; b < 3; b++) begin
			exp_q.push_back(single_wb(d[b]));
		end
		drain_expected(1'b1, "back-pressure release", first_wait);
		// The held writeback goes at the first falling edge after release
		assert (first_wait == 1) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: back-pressure: release delay %0d, expected 1",
				$time, first_wait);
		end
	endtask

	task automatic test_queue_full();
		wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0] d;
		wb_types_pkg::bank_wb_t                                q_resp [cache_cfg_pkg::WBQ_DEPTH];
		int                                                    first_wait;
		@(posedge clk);
		core_no_wb_slot <= 1'b1;
		// Bank 0 fills the output stage so bank 2 has to queue
		d = '0;
		d[0] = rand_resp();
		d[0].rd = 5'd7;
		push_banks(4'b0001, d);
		for (int i = 0; i < cache_cfg_pkg::WBQ_DEPTH; i++) begin
			q_resp[i] = rand_resp();
			q_resp[i].rd = cache_cfg_pkg::RD_BITS'(8 + i);
			@(posedge clk);
			bank_push[2] <= 1'b1;
			bank_data[2] <= q_resp[i];
		end
		@(posedge clk);
		bank_push <= '0;
		@(negedge clk);
		assert (bank_full == 4'b0100) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: queue full: bank_full %b, expected 0100",
				$time, bank_full);
		end
		check_wb(single_wb(d[0]), "queue full hold");
		@(posedge clk);
		core_no_wb_slot <= 1'b0;
		exp_q.push_back(single_wb(d[0]));
		for (int i = 0; i < cache_cfg_pkg::WBQ_DEPTH; i++) begin
			exp_q.push_back(single_wb(q_resp[i]));
		end
		drain_expected(1'b1, "queue full release", first_wait);
		assert (first_wait == 1) else begin
			check_errors++;
			$display("CHECK FAILED at %0t ns: queue full: release delay %0d, expected 1",
				$time, first_wait);
		end
	endtask

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Simulation timed out: tests did not finish within %0d cycles",
			TEST_CYCLES + MARGIN_CYCLES);
		$display("Errors: %0d check failures, %0d timeouts", check_errors, timeouts + 1);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		clk             = 1'b0;
		rst_n           = 1'b0;
		bank_push       = '0;
		bank_data       = '0;
		core_no_wb_slot = 1'b0;
		apply_reset();
		test_single_response();
		test_merge();
		test_priority();
		test_back_pressure();
		test_queue_full();
		$display("Errors: %0d check failures, %0d timeouts", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== tb/cache_wb_properties.sv ====
`timescale 1ns/1ps

module cache_wb_properties (
	input logic                                clk,
	input logic                                rst_n,
	input logic [cache_cfg_pkg::NUM_BANKS-1:0] bank_push,
	input logic [cache_cfg_pkg::NUM_BANKS-1:0] bank_full,
	input logic                                core_no_wb_slot,
	input logic                                core_wb_valid,
	input wb_types_pkg::core_wb_t              core_wb
);

	// A stalled writeback must not change under the core
	a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(core_wb_valid && core_no_wb_slot) |=> $stable(core_wb))
		else $error("core_wb changed while the core had no writeback slot");

	// Producer respects the full level of every bank
	a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(|(bank_push & bank_full)))
		else $error("bank_push asserted while bank_full was high");

	// Output starts idle once reset is released
	a_idle_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !core_wb_valid)
		else $error("core_wb_valid high in the cycle after reset release");

endmodule

bind cache_wb_top cache_wb_properties props0 (
	.clk             (clk),
	.rst_n           (rst_n),
	.bank_push       (bank_push),
	.bank_full       (bank_full),
	.core_no_wb_slot (core_no_wb_slot),
	.core_wb_valid   (core_wb_valid),
	.core_wb         (core_wb)
);

// ==== hdl/cache_wb_top.sv ====
`timescale 1ns/1ps

module cache_wb_top (
	input  logic                                                  clk,
	input  logic                                                  rst_n,
	input  logic [cache_cfg_pkg::NUM_BANKS-1:0]                   bank_push,
	input  wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0] bank_data,
	output logic [cache_cfg_pkg::NUM_BANKS-1:0]                   bank_full,
	input  logic                                                  core_no_wb_slot,
	output logic                                                  core_wb_valid,
	output wb_types_pkg::core_wb_t                                core_wb
);

	logic [cache_cfg_pkg::NUM_BANKS-1:0]                   heads_valid;
	wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0] heads;
	logic [cache_cfg_pkg::NUM_BANKS-1:0]                   pop;
	logic                                                  accept;
	logic                                                  merged_valid;
	wb_types_pkg::core_wb_t                                merged;

	// One writeback queue per bank
	for (genvar b = 0; b < cache_cfg_pkg::NUM_BANKS; b++) begin : g_bank_q
		bank_wb_queue bank_q (
			.clk        (clk),
			.rst_n      (rst_n),
			.push       (bank_push[b]),
			.push_data  (bank_data[b]),
			.pop        (pop[b]),
			.head_valid (heads_valid[b]),
			.head       (heads[b]),
			.full       (bank_full[b])
		);
	end

	wb_sel_merge sel_merge (
		.heads_valid  (heads_valid),
		.heads        (heads),
		.accept       (accept),
		.pop          (pop),
		.merged_valid (merged_valid),
		.merged       (merged)
	);

	core_wb_stage wb_stage (
		.clk             (clk),
		.rst_n           (rst_n),
		.core_no_wb_slot (core_no_wb_slot),
		.merged_valid    (merged_valid),
		.merged          (merged),
		.accept          (accept),
		.core_wb_valid   (core_wb_valid),
		.core_wb         (core_wb)
	);

endmodule

// ==== hdl/core_wb_stage.sv ====
`timescale 1ns/1ps

module core_wb_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   core_no_wb_slot,
	input  logic                   merged_valid,
	input  wb_types_pkg::core_wb_t merged,
	output logic                   accept,
	output logic                   core_wb_valid,
	output wb_types_pkg::core_wb_t core_wb
);

	// Take a new writeback when empty or when the core has a free slot
	assign accept = !core_wb_valid || !core_no_wb_slot;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			core_wb_valid <= 1'b0;
		end else if (accept) begin
			// Drops to idle when nothing is merged this cycle
			core_wb_valid <= merged_valid;
		end
	end

	// Payload only moves together with a valid merge result
	always_ff @(posedge clk) begin
		if (accept && merged_valid) begin
			core_wb <= merged;
		end
	end

endmodule

// ==== hdl/wb_sel_merge.sv ====
`timescale 1ns/1ps

module wb_sel_merge (
	input  logic [cache_cfg_pkg::NUM_BANKS-1:0]                         heads_valid,
	input  wb_types_pkg::bank_wb_t [cache_cfg_pkg::NUM_BANKS-1:0]       heads,
	input  logic                                                        accept,
	output logic [cache_cfg_pkg::NUM_BANKS-1:0]                         pop,
	output logic                                                        merged_valid,
	output wb_types_pkg::core_wb_t                                      merged
);

	localparam int NB = cache_cfg_pkg::NUM_BANKS;

	logic                                    found;
	logic [cache_cfg_pkg::BANK_IDX_BITS-1:0] main_idx;
	wb_types_pkg::bank_wb_t                  main_head;
	logic [NB-1:0]                           match;

	// Lowest numbered bank with a waiting response wins
	always_comb begin
		found    = 1'b0;
		main_idx = '0;
		for (int b = 0; b < NB; b++) begin
			if (heads_valid[b] && !found) begin
				found    = 1'b1;
				main_idx = cache_cfg_pkg::BANK_IDX_BITS'(b);
			end
		end
	end

	assign main_head = heads[main_idx];

	// Heads aimed at the same register of the same warp join this writeback
	always_comb begin
		for (int b = 0; b < NB; b++) begin
			match[b] = heads_valid[b]
				&& (heads[b].rd == main_head.rd)
				&& (heads[b].warp_num == main_head.warp_num);
		end
	end

	// Each matching head fills the lane named by its tid
	always_comb begin
		merged.lane_valid = '0;
		merged.lane_data  = '0;
		for (int b = 0; b < NB; b++) begin
			if (match[b]) begin
				merged.lane_valid[heads[b].tid] = 1'b1;
				merged.lane_data[heads[b].tid]  = heads[b].data;
			end
		end
	end

	// Destination fields come from the selected bank
	always_comb begin
		if (found) begin
			merged.rd       = main_head.rd;
			merged.wb       = main_head.wb;
			merged.warp_num = main_head.warp_num;
		end else begin
			merged.rd       = '0;
			merged.wb       = wb_types_pkg::WB_NONE;
			merged.warp_num = '0;
		end
	end

	assign merged_valid = found;

	// Merged heads leave only when the output stage takes the writeback
	assign pop = match & {NB{accept}};

endmodule

// ==== hdl/bank_wb_queue.sv ====
`timescale 1ns/1ps

module bank_wb_queue (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  push,
	input  wb_types_pkg::bank_wb_t push_data,
	input  logic                  pop,
	output logic                  head_valid,
	output wb_types_pkg::bank_wb_t head,
	output logic                  full
);

	localparam int DEPTH    = cache_cfg_pkg::WBQ_DEPTH;
	localparam int PTR_BITS = cache_cfg_pkg::WBQ_PTR_BITS;

	wb_types_pkg::bank_wb_t mem [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;

	logic do_push;
	logic do_pop;

	// A push while full is dropped, a pop while empty is ignored
	assign do_push = push && !full;
	assign do_pop  = pop && head_valid;

	assign head_valid = (count != '0);
	assign full       = (count == (PTR_BITS + 1)'(DEPTH));
	assign head       = mem[rd_ptr];

	// Storage array
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (do_push) begin
			if (wr_ptr == PTR_BITS'(DEPTH - 1)) begin
				wr_ptr <= '0;
			end else begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (do_pop) begin
			if (rd_ptr == PTR_BITS'(DEPTH - 1)) begin
				rd_ptr <= '0;
			end else begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy, push and pop on the same edge cancel out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== hdl/wb_types_pkg.sv ====
package wb_types_pkg;

	// How the core commits the returned word
	typedef enum logic [1:0] {
		WB_NONE  = 2'd0,
		WB_INT   = 2'd1,
		WB_FLOAT = 2'd2,
		WB_CSR   = 2'd3
	} wb_kind_t;

	// Finished read response from one bank
	typedef struct packed {
		logic [cache_cfg_pkg::TID_BITS-1:0]  tid;
		logic [cache_cfg_pkg::RD_BITS-1:0]   rd;
		wb_kind_t                            wb;
		logic [cache_cfg_pkg::WARP_BITS-1:0] warp_num;
		logic [cache_cfg_pkg::WORD_BITS-1:0] data;
	} bank_wb_t;

	// Merged writeback handed to the core, one word per request lane
	typedef struct packed {
		logic [cache_cfg_pkg::NUM_REQS-1:0]                                lane_valid;
		logic [cache_cfg_pkg::NUM_REQS-1:0][cache_cfg_pkg::WORD_BITS-1:0] lane_data;
		logic [cache_cfg_pkg::RD_BITS-1:0]                                 rd;
		wb_kind_t                                                          wb;
		logic [cache_cfg_pkg::WARP_BITS-1:0]                               warp_num;
	} core_wb_t;

endpackage

// ==== hdl/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

	// Cache geometry
	localparam int NUM_BANKS = 4;
	localparam int NUM_REQS  = 2;
	localparam int NUM_WARPS = 4;

	// Datapath widths
	localparam int WORD_BITS = 32;
	localparam int RD_BITS   = 5;

	// Entries in each bank writeback queue
	localparam int WBQ_DEPTH = 4;

	// Index widths, never narrower than one bit
	localparam int BANK_IDX_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
	localparam int TID_BITS      = (NUM_REQS > 1) ? $clog2(NUM_REQS) : 1;
	localparam int WARP_BITS     = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1;
	localparam int WBQ_PTR_BITS  = (WBQ_DEPTH > 1) ? $clog2(WBQ_DEPTH) : 1;

endpackage
